/* hdl/rv_core_macros.svh */
// RV32 mini core sizing

`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data path and register width
`define RV_XLEN 32

// 4 KB word memory
`define RV_MEM_WORDS 1024

// word address width for RV_MEM_WORDS
`define RV_WADDR_BITS 10

`endif

/* hdl/rv_core_pkg.sv */
// RV32 mini core shared types

`include "rv_core_macros.svh"

package rv_core_pkg;

    // ----------------------------------------
    // major opcodes of the supported subset
    // ----------------------------------------
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_imm   = 7'b0010011,
        op_store = 7'b0100011,
        op_reg   = 7'b0110011
    } opcode_e;

    // ----------------------------------------
    // core FSM
    // ----------------------------------------
    typedef enum logic [1:0] {
        st_fetch = 2'd0,
        st_exec  = 2'd1,
        st_mem   = 2'd2,
        st_halt  = 2'd3
    } core_state_e;

    // ----------------------------------------
    // one access to the banked word memory
    // ----------------------------------------
    typedef struct packed {
        logic                      en;
        logic                      we;
        logic [`RV_WADDR_BITS-1:0] addr;
        logic [`RV_XLEN-1:0]       wdata;
        // one bit per byte lane
        logic [3:0]                wmask;
    } mem_req_t;

endpackage

/* hdl/rv_mini_core.sv */
// RV32 multi-cycle mini core

`timescale 1ns/1ps

`include "rv_core_macros.svh"

module rv_mini_core (
    input  logic                clk,
    input  logic                reset,
    // fetch port
    output logic                instr_req,
    output logic [`RV_XLEN-1:0] instr_addr,
    input  logic                instr_gnt,
    input  logic [`RV_XLEN-1:0] instr_data,
    // data port
    output logic                data_rd_req,
    output logic                data_wr_req,
    output logic [`RV_XLEN-1:0] data_addr,
    output logic [`RV_XLEN-1:0] data_wr_data,
    input  logic                data_gnt,
    input  logic [`RV_XLEN-1:0] data_rd_data,
    // status
    output logic                halted,
    output logic [`RV_XLEN-1:0] halt_pc
);

    rv_core_pkg::core_state_e state;
    rv_core_pkg::opcode_e     opcode;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] ir;
    logic [`RV_XLEN-1:0] regs [32];

    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] opb;
    logic [`RV_XLEN-1:0] sum;

    logic                legal;
    logic                is_alu;
    logic                is_load;
    logic                is_store;
    logic                rf_we;
    logic [`RV_XLEN-1:0] rf_wdata;

    // ----------------------------------------
    // decode
    // ----------------------------------------
    assign opcode = rv_core_pkg::opcode_e'(ir[6:0]);
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign funct7 = ir[31:25];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};

    // only ADDI, ADD, LW and SW pass; anything else stops the core
    always_comb begin
        legal = 1'b0;
        case (opcode)
            rv_core_pkg::op_imm:   legal = (funct3 == 3'b000);
            rv_core_pkg::op_reg:   legal = (funct3 == 3'b000) && (funct7 == 7'b0000000);
            rv_core_pkg::op_load:  legal = (funct3 == 3'b010);
            rv_core_pkg::op_store: legal = (funct3 == 3'b010);
            default:               legal = 1'b0;
        endcase
    end

    assign is_alu   = (opcode == rv_core_pkg::op_imm) || (opcode == rv_core_pkg::op_reg);
    assign is_load  = (opcode == rv_core_pkg::op_load);
    assign is_store = (opcode == rv_core_pkg::op_store);

    // ----------------------------------------
    // operands and adder
    // ----------------------------------------
    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];

    always_comb begin
        case (opcode)
            rv_core_pkg::op_reg:   opb = rs2_val;
            rv_core_pkg::op_store: opb = imm_s;
            default:               opb = imm_i;
        endcase
    end

    // one adder serves ADDI, ADD and the load/store address
    assign sum = rs1_val + opb;

    // ----------------------------------------
    // register file
    // ----------------------------------------
    assign rf_we = ((state == rv_core_pkg::st_exec) && legal && is_alu) ||
                   ((state == rv_core_pkg::st_mem) && is_load && data_gnt);

    assign rf_wdata = (state == rv_core_pkg::st_mem) ? data_rd_data : sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && (rd != 5'd0)) begin
            // x0 stays zero
            regs[rd] <= rf_wdata;
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if ((state == rv_core_pkg::st_fetch) && instr_gnt) begin
            ir <= instr_data;
        end
    end

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= rv_core_pkg::st_fetch;
            pc      <= '0;
            halted  <= 1'b0;
            halt_pc <= '0;
        end else begin
            case (state)
                rv_core_pkg::st_fetch: begin
                    if (instr_gnt) begin
                        state <= rv_core_pkg::st_exec;
                    end
                end
                rv_core_pkg::st_exec: begin
                    if (!legal) begin
                        state   <= rv_core_pkg::st_halt;
                        halted  <= 1'b1;
                        halt_pc <= pc;
                    end else if (is_alu) begin
                        state <= rv_core_pkg::st_fetch;
                        pc    <= pc + 32'd4;
                    end else begin
                        state <= rv_core_pkg::st_mem;
                    end
                end
                rv_core_pkg::st_mem: begin
                    if (data_gnt) begin
                        state <= rv_core_pkg::st_fetch;
                        pc    <= pc + 32'd4;
                    end
                end
                default: begin
                    // parked until reset
                    state <= rv_core_pkg::st_halt;
                end
            endcase
        end
    end

    // ----------------------------------------
    // memory requests
    // ----------------------------------------
    // requests drop in their grant cycle so only one access is ever in flight
    assign instr_req  = (state == rv_core_pkg::st_fetch) && !instr_gnt;
    assign instr_addr = pc;

    assign data_rd_req  = (state == rv_core_pkg::st_mem) && is_load && !data_gnt;
    assign data_wr_req  = (state == rv_core_pkg::st_mem) && is_store && !data_gnt;
    assign data_addr    = sum;
    assign data_wr_data = rs2_val;

endmodule

/* hdl/mem_arbiter.sv */
// Shared memory access arbiter

`timescale 1ns/1ps

`include "rv_core_macros.svh"

module mem_arbiter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      run,
    // host port, word addressed
    input  logic                      host_en,
    input  logic                      host_we,
    input  logic [`RV_WADDR_BITS-1:0] host_addr,
    input  logic [`RV_XLEN-1:0]       host_wdata,
    input  logic [3:0]                host_wmask,
    // core ports, byte addressed
    input  logic                      instr_req,
    input  logic [`RV_XLEN-1:0]       instr_addr,
    input  logic                      data_rd_req,
    input  logic                      data_wr_req,
    input  logic [`RV_XLEN-1:0]       data_addr,
    input  logic [`RV_XLEN-1:0]       data_wr_data,
    // to the banks
    output rv_core_pkg::mem_req_t     bank_req,
    output logic                      instr_gnt,
    output logic                      data_gnt
);

    logic data_win;
    logic fetch_win;

    // host, then data, then fetch while running
    assign data_win  = !host_en && (data_rd_req || data_wr_req);
    assign fetch_win = !host_en && !(data_rd_req || data_wr_req) && instr_req && run;

    always_comb begin
        bank_req = '0;
        if (host_en) begin
            bank_req.en    = 1'b1;
            bank_req.we    = host_we;
            bank_req.addr  = host_addr;
            bank_req.wdata = host_wdata;
            bank_req.wmask = host_wmask;
        end else if (data_win) begin
            bank_req.en    = 1'b1;
            bank_req.we    = data_wr_req;
            bank_req.addr  = data_addr[2 +: `RV_WADDR_BITS];
            bank_req.wdata = data_wr_data;
            bank_req.wmask = 4'hf;
        end else if (fetch_win) begin
            bank_req.en   = 1'b1;
            bank_req.addr = instr_addr[2 +: `RV_WADDR_BITS];
        end
    end

    // grant lands with the read data of the banks
    always_ff @(posedge clk) begin
        if (reset) begin
            instr_gnt <= 1'b0;
            data_gnt  <= 1'b0;
        end else begin
            instr_gnt <= fetch_win;
            data_gnt  <= data_win;
        end
    end

endmodule

/* hdl/byte_lane_bank.sv */
// Byte-wide memory lane

`timescale 1ns/1ps

`include "rv_core_macros.svh"

module byte_lane_bank (
    input  logic                      clk,
    input  logic                      en,
    input  logic                      we,
    input  logic [`RV_WADDR_BITS-1:0] addr,
    input  logic [7:0]                wdata,
    output logic [7:0]                rdata
);

    logic [7:0] mem [`RV_MEM_WORDS];

    // single port with old data on a write cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

/* hdl/rv_core_top.sv */
// RV32 mini core with banked memory

`timescale 1ns/1ps

`include "rv_core_macros.svh"

module rv_core_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      run,
    input  logic                      host_en,
    input  logic                      host_we,
    input  logic [`RV_WADDR_BITS-1:0] host_addr,
    input  logic [`RV_XLEN-1:0]       host_wdata,
    input  logic [3:0]                host_wmask,
    output logic [`RV_XLEN-1:0]       host_rdata,
    output logic                      halted,
    output logic [`RV_XLEN-1:0]       halt_pc
);

    logic                  instr_req;
    logic [`RV_XLEN-1:0]   instr_addr;
    logic                  instr_gnt;
    logic                  data_rd_req;
    logic                  data_wr_req;
    logic [`RV_XLEN-1:0]   data_addr;
    logic [`RV_XLEN-1:0]   data_wr_data;
    logic                  data_gnt;
    logic [`RV_XLEN-1:0]   rdata;
    rv_core_pkg::mem_req_t bank_req;

    rv_mini_core i_rv_mini_core (
        .clk         (clk),
        .reset       (reset),
        .instr_req   (instr_req),
        .instr_addr  (instr_addr),
        .instr_gnt   (instr_gnt),
        .instr_data  (rdata),
        .data_rd_req (data_rd_req),
        .data_wr_req (data_wr_req),
        .data_addr   (data_addr),
        .data_wr_data(data_wr_data),
        .data_gnt    (data_gnt),
        .data_rd_data(rdata),
        .halted      (halted),
        .halt_pc     (halt_pc)
    );

    mem_arbiter i_mem_arbiter (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .host_en     (host_en),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_wmask  (host_wmask),
        .instr_req   (instr_req),
        .instr_addr  (instr_addr),
        .data_rd_req (data_rd_req),
        .data_wr_req (data_wr_req),
        .data_addr   (data_addr),
        .data_wr_data(data_wr_data),
        .bank_req    (bank_req),
        .instr_gnt   (instr_gnt),
        .data_gnt    (data_gnt)
    );

    // ----------------------------------------
    // four byte lanes make one word
    // ----------------------------------------
    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        byte_lane_bank i_byte_lane_bank (
            .clk  (clk),
            .en   (bank_req.en),
            .we   (bank_req.we && bank_req.wmask[lane]),
            .addr (bank_req.addr),
            .wdata(bank_req.wdata[8*lane +: 8]),
            .rdata(rdata[8*lane +: 8])
        );
    end

    // host reads share the bank outputs
    assign host_rdata = rdata;

endmodule

/* tests/tb_rv_core_top.sv */
// Testbench for the RV32 mini core

`timescale 1ns/1ps

`include "rv_core_macros.svh"

module tb_rv_core_top;

    logic                      clk;
    logic                      reset;
    logic                      run;
    logic                      host_en;
    logic                      host_we;
    logic [`RV_WADDR_BITS-1:0] host_addr;
    logic [`RV_XLEN-1:0]       host_wdata;
    logic [3:0]                host_wmask;
    logic [`RV_XLEN-1:0]       host_rdata;
    logic                      halted;
    logic [`RV_XLEN-1:0]       halt_pc;

    integer      seed;
    logic [31:0] prog [$];

    rv_core_top i_rv_core_top (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .host_en   (host_en),
        .host_we   (host_we),
        .host_addr (host_addr),
        .host_wdata(host_wdata),
        .host_wmask(host_wmask),
        .host_rdata(host_rdata),
        .halted    (halted),
        .halt_pc   (halt_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // instruction encoders
    // ----------------------------------------
    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        addi_word = {imm, rs1, 3'b000, rd, rv_core_pkg::op_imm};
    endfunction

    function automatic logic [31:0] add_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        add_word = {7'b0000000, rs2, rs1, 3'b000, rd, rv_core_pkg::op_reg};
    endfunction

    function automatic logic [31:0] lw_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        lw_word = {imm, rs1, 3'b010, rd, rv_core_pkg::op_load};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        sw_word = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_core_pkg::op_store};
    endfunction

    // opcode 7'h7f is outside the subset
    function automatic logic [31:0] illegal_word();
        illegal_word = {25'h0, 7'h7f};
    endfunction

    function automatic int rand_below(input int limit);
        rand_below = ($random(seed) & 32'h7fff_ffff) % limit;
    endfunction

    // ----------------------------------------
    // host access and run control
    // ----------------------------------------
    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s, got %08h, expected %08h", $time, msg, actual,
                     expected);
            abort_run();
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        reset   = 1'b1;
        run     = 1'b0;
        host_en = 1'b0;
        host_we = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic host_write(input int addr, input logic [31:0] data, input logic [3:0] mask);
        @(negedge clk);
        host_en    = 1'b1;
        host_we    = 1'b1;
        host_addr  = addr[`RV_WADDR_BITS-1:0];
        host_wdata = data;
        host_wmask = mask;
        @(negedge clk);
        host_en = 1'b0;
        host_we = 1'b0;
    endtask

    // data shows one clock after the request
    task automatic host_read(input int addr, output logic [31:0] result);
        @(negedge clk);
        host_en   = 1'b1;
        host_we   = 1'b0;
        host_addr = addr[`RV_WADDR_BITS-1:0];
        @(negedge clk);
        host_en = 1'b0;
        result  = host_rdata;
    endtask

    // reset with run low, then the host owns the memory
    task automatic load_program();
        reset_dut();
        foreach (prog[i]) host_write(i, prog[i], 4'hf);
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        while (!halted && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timeout: the core never halted within 5000 cycles");
            abort_run();
        end
    endtask

    task automatic start_program();
        @(negedge clk);
        run = 1'b1;
        wait_halt();
    endtask

    // x5 = 3840 is the byte address of word 960
    task automatic push_base();
        prog.push_back(addi_word(5'd5, 5'd0, 12'd1920));
        prog.push_back(add_word(5'd5, 5'd5, 5'd5));
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic byte_masks_test();
        int          addr;
        logic [31:0] old_word;
        logic [31:0] new_word;
        logic [31:0] expected;
        logic [31:0] got;
        logic [31:0] rnd;
        logic [3:0]  mask;
        addr     = rand_below(`RV_MEM_WORDS);
        old_word = $random(seed);
        new_word = $random(seed);
        rnd      = $random(seed);
        mask     = rnd[3:0];
        host_write(addr, old_word, 4'hf);
        host_write(addr, new_word, mask);
        for (int lane = 0; lane < 4; lane++) begin
            expected[8*lane +: 8] = mask[lane] ? new_word[8*lane +: 8] : old_word[8*lane +: 8];
        end
        host_read(addr, got);
        check_eq(got, expected, "masked host write");
    endtask

    task automatic doubler_test(input int n, input bit gated);
        logic [31:0] got;
        prog.delete();
        push_base();
        prog.push_back(addi_word(5'd1, 5'd0, 12'd1));
        for (int i = 0; i < n; i++) prog.push_back(add_word(5'd1, 5'd1, 5'd1));
        prog.push_back(sw_word(5'd1, 5'd5, 12'd0));
        prog.push_back(illegal_word());
        load_program();
        if (gated) begin
            // no fetch may be granted while run is low
            for (int i = 0; i < 200; i++) begin
                @(negedge clk);
                check_eq({31'd0, halted}, 32'd0, "halted with run low");
            end
        end
        start_program();
        check_eq(halt_pc, 4 * (prog.size() - 1), "doubler halt pc");
        host_read(960, got);
        check_eq(got, 32'd1 << n, "doubler result");
    endtask

    task automatic fibonacci_test();
        int          n;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] got;
        n = 1 + rand_below(32);
        a = 32'd0;
        b = 32'd1;
        c = 32'd0;
        prog.delete();
        push_base();
        prog.push_back(addi_word(5'd1, 5'd0, 12'd0));
        prog.push_back(addi_word(5'd2, 5'd0, 12'd1));
        for (int i = 0; i < n; i++) begin
            prog.push_back(add_word(5'd3, 5'd1, 5'd2));
            prog.push_back(add_word(5'd1, 5'd2, 5'd0));
            prog.push_back(add_word(5'd2, 5'd3, 5'd0));
            c = a + b;
            a = b;
            b = c;
        end
        prog.push_back(sw_word(5'd1, 5'd5, 12'd0));
        prog.push_back(sw_word(5'd2, 5'd5, 12'd4));
        prog.push_back(sw_word(5'd3, 5'd5, 12'd8));
        prog.push_back(illegal_word());
        load_program();
        start_program();
        host_read(960, got);
        check_eq(got, a, "fibonacci x1");
        host_read(961, got);
        check_eq(got, b, "fibonacci x2");
        host_read(962, got);
        check_eq(got, c, "fibonacci x3");
    endtask

    task automatic load_add_store_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        a = $random(seed);
        b = $random(seed);
        prog.delete();
        push_base();
        prog.push_back(lw_word(5'd6, 5'd5, 12'd40));
        prog.push_back(lw_word(5'd7, 5'd5, 12'd44));
        prog.push_back(add_word(5'd8, 5'd6, 5'd7));
        // both writes to x0 must vanish
        prog.push_back(addi_word(5'd0, 5'd0, 12'd123));
        prog.push_back(add_word(5'd0, 5'd6, 5'd7));
        prog.push_back(sw_word(5'd8, 5'd5, 12'd0));
        prog.push_back(sw_word(5'd0, 5'd5, 12'd4));
        prog.push_back(illegal_word());
        load_program();
        host_write(970, a, 4'hf);
        host_write(971, b, 4'hf);
        host_write(961, 32'hffff_ffff, 4'hf);
        start_program();
        host_read(960, got);
        check_eq(got, a + b, "load/add/store sum");
        host_read(961, got);
        check_eq(got, 32'd0, "stored x0");
    endtask

    task automatic illegal_stop_test();
        int          k;
        logic [31:0] got;
        k = rand_below(16);
        prog.delete();
        for (int i = 0; i < k; i++) prog.push_back(addi_word(5'd1, 5'd1, 12'd1));
        prog.push_back(illegal_word());
        push_base();
        prog.push_back(sw_word(5'd1, 5'd5, 12'd0));
        load_program();
        host_write(960, 32'h5a5a_a5a5, 4'hf);
        start_program();
        check_eq(halt_pc, 4 * k, "illegal halt pc");
        host_read(960, got);
        check_eq(got, 32'h5a5a_a5a5, "memory after illegal stop");
    endtask

    initial begin
        reset      = 1'b1;
        run        = 1'b0;
        host_en    = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        host_wmask = '0;
        seed       = 95203;
        reset_dut();
        byte_masks_test();
        doubler_test(1 + rand_below(31), 1'b0);
        fibonacci_test();
        load_add_store_test();
        // run held low before the start
        doubler_test(1 + rand_below(31), 1'b1);
        illegal_stop_test();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* build.f */
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/rv_mini_core.sv
hdl/mem_arbiter.sv
hdl/byte_lane_bank.sv
hdl/rv_core_top.sv
tests/tb_rv_core_top.sv
